// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
	input zhx_pkg::alu_fn_t fn,
	input zhx_pkg::word_t a,
	input zhx_pkg::word_t b,
	output zhx_pkg::word_t y
);
	import zhx_pkg::*;

	logic [3:0] shamt;

	// shifts use only the low four bits
	assign shamt = b[3:0];

	always_comb begin
		case (fn)
			FN_ADD: y = a + b;
			FN_SUB: y = a - b;
			FN_AND: y = a & b;
			FN_OR: y = a | b;
			FN_XOR: y = a ^ b;
			// signed compare
			FN_SLT: y = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
			FN_SLL: y = a << shamt;
			FN_SRL: y = a >> shamt;
			default: y = '0;
		endcase
	end

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps

module decoder (
	input logic clk,
	input logic rst_n,
	input logic hold,
	input zhx_pkg::word_t id_pc,
	input zhx_pkg::word_t id_inst,
	output zhx_pkg::reg_addr_t raddr1,
	output zhx_pkg::reg_addr_t raddr2,
	input zhx_pkg::word_t rdata1,
	input zhx_pkg::word_t rdata2,
	input logic fwd_we,
	input zhx_pkg::reg_addr_t fwd_addr,
	input zhx_pkg::word_t fwd_data,
	output logic redirect,
	output zhx_pkg::word_t redirect_pc,
	output zhx_pkg::alu_fn_t ex_fn,
	output zhx_pkg::word_t ex_op1,
	output zhx_pkg::word_t ex_op2,
	output zhx_pkg::word_t ex_store,
	output zhx_pkg::reg_addr_t ex_rd,
	output logic ex_we,
	output logic ex_load,
	output logic ex_storeop
);
	import zhx_pkg::*;

	inst_t inst;
	opcode_t op;
	word_t imm;
	word_t val_a;
	word_t val_b;
	logic taken;

	alu_fn_t nx_fn;
	word_t nx_op2;
	logic nx_we;
	logic nx_load;
	logic nx_store;

	assign inst = id_inst;
	assign op = inst.r.opcode;
	assign imm = sext6(inst.i.imm);

	// rs sits in the same place in both forms, second port reads rt or rd
	assign raddr1 = inst.r.rs;
	assign raddr2 = (op == OP_ALU) ? inst.r.rt : inst.r.rd;

	// newest value comes from the instruction in execute
	assign val_a = (fwd_we && fwd_addr == raddr1) ? fwd_data : rdata1;
	assign val_b = (fwd_we && fwd_addr == raddr2) ? fwd_data : rdata2;

	// branches test rd, resolved here
	always_comb begin
		case (op)
			OP_BEQZ: taken = (val_b == '0);
			OP_BNEZ: taken = (val_b != '0);
			default: taken = 1'b0;
		endcase
	end

	assign redirect = taken && !hold;
	assign redirect_pc = id_pc + 16'd1 + imm;

	always_comb begin
		nx_fn = FN_ADD;
		nx_op2 = imm;
		nx_we = 1'b0;
		nx_load = 1'b0;
		nx_store = 1'b0;
		case (op)
			OP_ALU: begin
				nx_fn = inst.r.fn;
				nx_op2 = val_b;
				nx_we = 1'b1;
			end
			OP_ADDI: nx_we = 1'b1;
			OP_LW: begin
				nx_we = 1'b1;
				nx_load = 1'b1;
			end
			OP_SW: nx_store = 1'b1;
			// nop, branches and unknown opcodes issue a bubble
			default: ;
		endcase
	end

	// id/exe register, control part
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_we <= 1'b0;
			ex_load <= 1'b0;
			ex_storeop <= 1'b0;
		end else if (!hold) begin
			ex_we <= nx_we && (inst.r.rd != 3'd0);
			ex_load <= nx_load;
			ex_storeop <= nx_store;
		end
	end

	// operands and destination
	always_ff @(posedge clk) begin
		if (!hold) begin
			ex_fn <= nx_fn;
			ex_op1 <= val_a;
			ex_op2 <= nx_op2;
			ex_store <= val_b;
			ex_rd <= inst.r.rd;
		end
	end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
	parameter zhx_pkg::word_t RESET_PC = 16'h0000
) (
	input logic clk,
	input logic rst_n,
	input logic hold,
	input logic redirect,
	input zhx_pkg::word_t redirect_pc,
	input zhx_pkg::word_t inst_data,
	output zhx_pkg::word_t inst_addr,
	output zhx_pkg::word_t id_pc,
	output zhx_pkg::word_t id_inst
);
	import zhx_pkg::*;

	word_t pc;

	// instruction memory answers in the same cycle
	assign inst_addr = pc;

	// program counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (!hold) begin
			if (redirect)
				pc <= redirect_pc;
			else
				pc <= pc + 16'd1;
		end
	end

	// if/id register, a taken branch squashes the word fetched behind it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_inst <= NOP_WORD;
		end else if (!hold) begin
			if (redirect)
				id_inst <= NOP_WORD;
			else
				id_inst <= inst_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold)
			id_pc <= pc;
	end

endmodule

// ==== design/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic store,
	input zhx_pkg::word_t addr,
	input zhx_pkg::word_t wdata,
	output logic hold,
	output logic done,
	output zhx_pkg::word_t rdata,
	output logic mem_req,
	output logic mem_we,
	output zhx_pkg::word_t mem_addr,
	output zhx_pkg::word_t mem_wdata,
	input logic mem_ack,
	input zhx_pkg::word_t mem_rdata
);
	import zhx_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ = 2'd1;
	localparam logic [1:0] ST_REL = 2'd2;
	localparam logic [1:0] ST_DONE = 2'd3;

	logic [1:0] state;
	logic access;

	assign access = load || store;

	// four-phase handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			mem_we <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					mem_we <= store;
					// never raise req over a stale ack
					if (access && !mem_ack)
						state <= ST_REQ;
				end
				ST_REQ: if (mem_ack) state <= ST_REL;
				ST_REL: if (!mem_ack) state <= ST_DONE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			mem_addr <= addr;
			mem_wdata <= wdata;
		end
		// read data valid on the first edge with ack high
		if (state == ST_REQ && mem_ack)
			rdata <= mem_rdata;
	end

	assign mem_req = (state == ST_REQ);
	assign done = (state == ST_DONE);
	// pipeline stalls until the ack has fallen again
	assign hold = access && (state != ST_DONE);

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic rst_n,
	input logic we,
	input zhx_pkg::reg_addr_t waddr,
	input zhx_pkg::word_t wdata,
	input zhx_pkg::reg_addr_t raddr1,
	input zhx_pkg::reg_addr_t raddr2,
	output zhx_pkg::word_t rdata1,
	output zhx_pkg::word_t rdata2
);
	import zhx_pkg::*;

	word_t regs [8];
	logic wr_ok;

	// r0 never takes a write
	assign wr_ok = we && (waddr != 3'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < 8; k++)
				regs[k] <= '0;
		end else if (wr_ok) begin
			regs[waddr] <= wdata;
		end
	end

	// bypass the value being written this cycle
	assign rdata1 = (wr_ok && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (wr_ok && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// ==== design/zhx_pkg.sv ====
package zhx_pkg;

	// one data word, also one memory address
	typedef logic [15:0] word_t;

	typedef logic [2:0] reg_addr_t;

	// values not listed here decode as nop
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ALU  = 4'd1,
		OP_ADDI = 4'd2,
		OP_LW   = 4'd3,
		OP_SW   = 4'd4,
		OP_BEQZ = 4'd5,
		OP_BNEZ = 4'd6
	} opcode_t;

	typedef enum logic [2:0] {
		FN_ADD = 3'd0,
		FN_SUB = 3'd1,
		FN_AND = 3'd2,
		FN_OR  = 3'd3,
		FN_XOR = 3'd4,
		FN_SLT = 3'd5,
		FN_SLL = 3'd6,
		FN_SRL = 3'd7
	} alu_fn_t;

	// register-register form
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		alu_fn_t   fn;
	} inst_r_t;

	// immediate form, imm is two's complement
	typedef struct packed {
		opcode_t          opcode;
		reg_addr_t        rd;
		reg_addr_t        rs;
		logic signed [5:0] imm;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_t;

	// all-zero word is OP_NOP
	localparam word_t NOP_WORD = 16'h0000;

	function automatic word_t sext6(input logic [5:0] v);
		return {{10{v[5]}}, v};
	endfunction

endpackage

// ==== design/zhxpu.sv ====
`timescale 1ns/1ps

module zhxpu #(
	parameter zhx_pkg::word_t RESET_PC = 16'h0000
) (
	input logic clk,
	input logic rst_n,
	output zhx_pkg::word_t inst_addr,
	input zhx_pkg::word_t inst_data,
	output logic mem_req,
	output logic mem_we,
	output zhx_pkg::word_t mem_addr,
	output zhx_pkg::word_t mem_wdata,
	input logic mem_ack,
	input zhx_pkg::word_t mem_rdata
);
	import zhx_pkg::*;

	logic hold;
	logic redirect;
	word_t redirect_pc;
	word_t id_pc;
	word_t id_inst;

	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t rdata1;
	word_t rdata2;

	alu_fn_t ex_fn;
	word_t ex_op1;
	word_t ex_op2;
	word_t ex_store;
	reg_addr_t ex_rd;
	logic ex_we;
	logic ex_load;
	logic ex_storeop;
	word_t alu_y;

	logic mem_done;
	word_t load_data;
	word_t ex_result;
	logic fwd_we;

	logic wb_we;
	reg_addr_t wb_rd;
	word_t wb_data;

	fetch_unit #(.RESET_PC(RESET_PC)) __fetch_unit (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.inst_data(inst_data),
		.inst_addr(inst_addr),
		.id_pc(id_pc),
		.id_inst(id_inst)
	);

	register_file __register_file (
		.clk(clk),
		.rst_n(rst_n),
		.we(wb_we),
		.waddr(wb_rd),
		.wdata(wb_data),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	decoder __decoder (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.id_pc(id_pc),
		.id_inst(id_inst),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.fwd_we(fwd_we),
		.fwd_addr(ex_rd),
		.fwd_data(ex_result),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_fn(ex_fn),
		.ex_op1(ex_op1),
		.ex_op2(ex_op2),
		.ex_store(ex_store),
		.ex_rd(ex_rd),
		.ex_we(ex_we),
		.ex_load(ex_load),
		.ex_storeop(ex_storeop)
	);

	alu __alu (
		.fn(ex_fn),
		.a(ex_op1),
		.b(ex_op2),
		.y(alu_y)
	);

	mem_ctrl __mem_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.load(ex_load),
		.store(ex_storeop),
		.addr(alu_y),
		.wdata(ex_store),
		.hold(hold),
		.done(mem_done),
		.rdata(load_data),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	// execute result, also the forwarding source
	assign ex_result = ex_load ? load_data : alu_y;
	// load data only counts once the handshake is done
	assign fwd_we = ex_we && (!ex_load || mem_done);

	// exe/wb register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_we <= 1'b0;
		else if (!hold)
			wb_we <= ex_we;
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			wb_rd <= ex_rd;
			wb_data <= ex_result;
		end
	end

endmodule

// ==== list.f ====
design/zhx_pkg.sv
design/fetch_unit.sv
design/register_file.sv
design/decoder.sv
design/alu.sv
design/mem_ctrl.sv
design/zhxpu.sv
testbench/zhxpu_checker.sv
testbench/zhxpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run; exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module zhxpu_tb -f list.f -o zhxpu_sim &&
./obj_dir/zhxpu_sim || exit 1

// ==== testbench/zhxpu_checker.sv ====
`timescale 1ns/1ps

module zhxpu_checker (
	input logic clk,
	input logic rst_n,
	input logic mem_req,
	input logic mem_we,
	input logic mem_ack,
	input zhx_pkg::word_t mem_addr,
	input zhx_pkg::word_t mem_wdata
);
	import zhx_pkg::*;

	// address, direction and data held for the whole request
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req && $past(mem_req)) |->
		($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
		else $error("mem_addr, mem_we or mem_wdata changed during a request");

	// req only drops after the ack was seen
	req_holds: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mem_req) |-> $past(mem_ack))
		else $error("mem_req fell before mem_ack was seen high");

	// no new request over a stale ack
	req_after_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req) |-> !$past(mem_ack))
		else $error("mem_req rose while mem_ack was still high");

endmodule

bind zhxpu zhxpu_checker chk (.*);

// ==== testbench/zhxpu_tb.sv ====
`timescale 1ns/1ps

module zhxpu_tb;
	import zhx_pkg::*;

	localparam word_t reset_pc = 16'h0000;
	// summed length of all test programs, halts included
	localparam int prog_total = 59;
	// per instruction, plus two ack delays of three cycles per access
	localparam int run_limit = prog_total * 200 + prog_total * 6;

	logic clk;
	logic rst_n;
	word_t inst_addr;
	word_t inst_data;
	logic mem_req;
	logic mem_we;
	word_t mem_addr;
	word_t mem_wdata;
	logic mem_ack;
	word_t mem_rdata;

	word_t prog [64];
	word_t dmem [256];
	int prog_len;
	logic [15:0] rng;
	string test_name;
	word_t halt_pc;
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t got_addr [$];
	word_t got_data [$];

	zhxpu #(.RESET_PC(reset_pc)) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	// instruction memory answers combinationally
	assign inst_data = prog[inst_addr[5:0]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int next_delay();
		rng = rng ^ (rng << 7);
		rng = rng ^ (rng >> 9);
		rng = rng ^ (rng << 8);
		return int'(rng[1:0]);
	endfunction

	function automatic word_t fill_value(input int a);
		logic [7:0] b;
		b = a[7:0];
		return {b ^ 8'h3c, ~b};
	endfunction

	function automatic word_t enc_r(input int fn, input int rd, input int rs, input int rt);
		return {4'd1, rd[2:0], rs[2:0], rt[2:0], fn[2:0]};
	endfunction

	function automatic word_t enc_i(input int op, input int rd, input int rs, input int imm);
		return {op[3:0], rd[2:0], rs[2:0], imm[5:0]};
	endfunction

	task automatic emit(input word_t w);
		prog[prog_len] = w;
		prog_len = prog_len + 1;
	endtask

	// data memory, four-phase slave with random ack delays
	initial begin
		word_t a;
		int d;
		mem_ack = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_req && !mem_ack) begin
				a = mem_addr;
				d = next_delay();
				repeat (d) @(negedge clk);
				@(posedge clk);
				#1;
				if (mem_we) begin
					dmem[a[7:0]] = mem_wdata;
					got_addr.push_back(a);
					got_data.push_back(mem_wdata);
				end
				mem_rdata = dmem[a[7:0]];
				mem_ack = 1'b1;
				do @(negedge clk); while (mem_req);
				d = next_delay();
				repeat (d) @(negedge clk);
				@(posedge clk);
				#1 mem_ack = 1'b0;
			end
		end
	end

	initial begin
		repeat (run_limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", run_limit);
		$display("Finished with errors");
		$fatal(1);
	end

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Fail %s inst_addr: expected %h, actual %h", test_name, exp, act);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// reference model of the instruction set
	task automatic interpret();
		word_t gr [8];
		word_t gm [256];
		word_t pc;
		word_t w;
		word_t a;
		word_t b;
		word_t imm;
		word_t y;
		logic [3:0] op;
		int steps;
		for (int k = 0; k < 8; k++)
			gr[k] = '0;
		for (int k = 0; k < 256; k++)
			gm[k] = fill_value(k);
		exp_addr.delete();
		exp_data.delete();
		pc = reset_pc;
		steps = 0;
		while (steps < 500 && prog[pc[5:0]] != enc_i(OP_BEQZ, 0, 0, -1)) begin
			w = prog[pc[5:0]];
			op = w[15:12];
			a = gr[w[8:6]];
			b = gr[w[5:3]];
			imm = {{10{w[5]}}, w[5:0]};
			y = a + imm;
			case (w[2:0])
				3'd0: b = a + b;
				3'd1: b = a - b;
				3'd2: b = a & b;
				3'd3: b = a | b;
				3'd4: b = a ^ b;
				3'd5: b = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
				3'd6: b = a << b[3:0];
				default: b = a >> b[3:0];
			endcase
			pc = pc + 16'd1;
			if (op == OP_ALU) begin
				gr[w[11:9]] = b;
			end else if (op == OP_ADDI) begin
				gr[w[11:9]] = y;
			end else if (op == OP_LW) begin
				gr[w[11:9]] = gm[y[7:0]];
			end else if (op == OP_SW) begin
				gm[y[7:0]] = gr[w[11:9]];
				exp_addr.push_back(y);
				exp_data.push_back(gr[w[11:9]]);
			end else if (op == OP_BEQZ && gr[w[11:9]] == '0) begin
				pc = pc + imm;
			end else if (op == OP_BNEZ && gr[w[11:9]] != '0) begin
				pc = pc + imm;
			end
			gr[0] = '0;
			steps++;
		end
		halt_pc = pc;
	endtask

	task automatic run_program(input string name);
		test_name = name;
		emit(enc_i(OP_BEQZ, 0, 0, -1));
		interpret();
		for (int k = 0; k < 256; k++)
			dmem[k] = fill_value(k);
		got_addr.delete();
		got_data.delete();
		@(posedge clk);
		#1 rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		check_addr(reset_pc, inst_addr);
		check_bit("mem_req", 1'b0, mem_req);
		@(negedge clk);
		while (!(got_addr.size() >= exp_addr.size() && inst_addr == halt_pc))
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_word("store count", word_t'(exp_addr.size()), word_t'(got_addr.size()));
		for (int k = 0; k < exp_addr.size(); k++) begin
			check_word("store address", exp_addr[k], got_addr[k]);
			check_word("store data", exp_data[k], got_data[k]);
		end
	endtask

	task automatic test_alu_forwarding();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 5));
		emit(enc_i(OP_ADDI, 2, 1, -3));
		emit(enc_i(OP_ADDI, 4, 0, -20));
		for (int f = 0; f < 8; f++) begin
			// slt and srl take the negative operand first
			if (f == 5 || f == 7)
				emit(enc_r(f, 3, 4, 2));
			else
				emit(enc_r(f, 3, 1, 2));
			emit(enc_i(OP_SW, 3, 0, f + 1));
		end
		run_program("alu_forwarding");
	endtask

	task automatic test_load_store();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 10));
		emit(enc_i(OP_LW, 2, 0, 5));
		emit(enc_r(FN_ADD, 4, 2, 2));
		emit(enc_i(OP_SW, 4, 0, 6));
		emit(enc_i(OP_LW, 5, 0, 6));
		emit(enc_i(OP_SW, 5, 1, 1));
		emit(enc_i(OP_SW, 2, 1, -2));
		emit(enc_i(OP_LW, 6, 1, 1));
		emit(enc_i(OP_SW, 6, 0, 30));
		emit(enc_i(OP_LW, 7, 0, 31));
		emit(enc_i(OP_SW, 7, 7, 0));
		run_program("load_store");
	endtask

	task automatic test_branches();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 1));
		emit(enc_i(OP_BEQZ, 1, 0, 1));
		emit(enc_i(OP_SW, 1, 0, 40));
		emit(enc_i(OP_BNEZ, 1, 0, 1));
		emit(enc_i(OP_SW, 1, 0, 41));
		emit(enc_i(OP_BEQZ, 0, 0, 2));
		emit(enc_i(OP_ADDI, 1, 1, 5));
		emit(enc_i(OP_SW, 1, 0, 44));
		emit(enc_i(OP_SW, 1, 0, 42));
		emit(enc_i(OP_ADDI, 2, 0, 0));
		emit(enc_i(OP_BNEZ, 2, 0, 1));
		emit(enc_i(OP_SW, 2, 0, 43));
		emit(enc_i(OP_LW, 3, 0, 2));
		emit(enc_i(OP_BNEZ, 3, 0, 1));
		emit(enc_i(OP_SW, 3, 0, 45));
		emit(enc_i(OP_SW, 3, 0, 46));
		run_program("branches");
	endtask

	task automatic test_r0_and_unknown();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 0, 0, 7));
		emit(enc_r(FN_SUB, 0, 0, 4));
		emit(enc_i(OP_SW, 0, 0, 50));
		emit(enc_i(OP_ADDI, 1, 0, 3));
		emit(enc_i(9, 1, 1, 12));
		emit(16'hf3ff);
		emit(enc_i(7, 1, 0, 1));
		emit(enc_i(OP_SW, 1, 0, 51));
		emit(enc_i(OP_SW, 0, 1, 0));
		run_program("r0_and_unknown");
	endtask

	initial begin
		rng = 16'd149;
		rst_n = 1'b0;
		prog_len = 0;
		for (int k = 0; k < 64; k++)
			prog[k] = '0;
		test_alu_forwarding();
		test_load_store();
		test_branches();
		test_r0_and_unknown();
		$display("Finished with no errors");
		$finish;
	end

endmodule
